// File: verilog/gnss_params.svh
// ==================================================
// Shared macros of the GNSS time receiver
// Serial bit timing, NMEA sentence limits, ASCII codes
// ==================================================
`ifndef GNSS_PARAMS_SVH
`define GNSS_PARAMS_SVH

// ==================================================
// Serial line
// ==================================================
// Short bit period keeps simulation fast
`define GNSS_CLKS_PER_BIT 16

// ==================================================
// Sentence limits
// ==================================================
// NMEA allows 80 characters between "$" and "*"
`define GNSS_MAX_PAYLOAD 80
// Enough for "GPRMC,hhmmss.sss"
`define GNSS_FIELD_BYTES 16

// ==================================================
// ASCII codes
// ==================================================
`define GNSS_CHAR_START 8'h24
`define GNSS_CHAR_STAR  8'h2A
`define GNSS_CHAR_COMMA 8'h2C
`define GNSS_CHAR_DOT   8'h2E
`define GNSS_CHAR_ZERO  8'h30

`endif

// File: verilog/gnss_pkg.sv
// ==================================================
// Types shared by the GNSS time receiver stages
// Received character, field buffer, time of day
// ==================================================
`default_nettype none
`include "gnss_params.svh"

package gnss_pkg;

    // ==================================================
    // Serial and framing data
    // ==================================================

    // One character off the serial line
    typedef logic [7:0] nmea_char_t;

    // Leading payload bytes of a sentence
    // Payload byte 0 in the lowest byte lane
    typedef nmea_char_t [`GNSS_FIELD_BYTES-1:0] field_buf_t;

    // ==================================================
    // Decoded time
    // ==================================================

    // Seconds since midnight UTC, 0 to 86399
    typedef logic [16:0] sec_of_day_t;

    // Milliseconds within the second, 0 to 999
    typedef logic [9:0] millis_t;

endpackage

`default_nettype wire

// File: verilog/uart_rx.sv
// ==================================================
// Serial receiver, 8 data bits, no parity, 1 stop bit
// Two-flop synchronizer and mid-bit sampling FSM
// ==================================================
`timescale 1ns/1ps
`default_nettype none
`include "gnss_params.svh"

module uart_rx #(
    parameter int CLKS_PER_BIT = `GNSS_CLKS_PER_BIT  // Clock cycles per bit, 4 or more
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rx,        // Raw serial line, idle high
    output gnss_pkg::nmea_char_t rx_data,   // Last received byte
    output logic                 rx_valid   // One-cycle byte strobe
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'((CLKS_PER_BIT - 1) / 2);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } state_t;

    state_t               state;
    logic [CNT_W-1:0]     clk_cnt;     // Cycles within current bit
    logic [2:0]           bit_idx;     // Data bit number
    logic                 rx_meta;     // First synchronizer stage
    logic                 rx_sync;     // Synchronized line level
    logic                 sample_bit;  // Middle of a data bit
    gnss_pkg::nmea_char_t shift_reg;

    assign sample_bit = (state == ST_DATA) && (clk_cnt == FULL_BIT);
    assign rx_data    = shift_reg;

    // ==================================================
    // Synchronizer and bit FSM
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta  <= 1'b1;              // Line idles high
            rx_sync  <= 1'b1;
            state    <= ST_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_meta  <= rx;
            rx_sync  <= rx_meta;
            rx_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_sync) begin
                        state <= ST_START;      // Falling start edge
                    end
                end
                ST_START: begin
                    if (clk_cnt != HALF_BIT) begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end else if (!rx_sync) begin
                        clk_cnt <= '0;          // Now aligned to bit centers
                        state   <= ST_DATA;
                    end else begin
                        state <= ST_IDLE;       // Glitch, not a start bit
                    end
                end
                ST_DATA: begin
                    if (!sample_bit) begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end else begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= ST_STOP;
                        end
                    end
                end
                ST_STOP: begin
                    if (clk_cnt != FULL_BIT) begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end else begin
                        rx_valid <= 1'b1;       // Byte complete
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ==================================================
    // Data shift register, LSB arrives first
    // ==================================================
    always_ff @(posedge clk) begin
        if (sample_bit) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
    end

endmodule

`default_nettype wire

// File: verilog/nmea_framer.sv
// ==================================================
// NMEA sentence framer
// XOR checksum check on the second hex digit
// Capture of the leading payload bytes
// ==================================================
`timescale 1ns/1ps
`default_nettype none
`include "gnss_params.svh"

module nmea_framer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 enable,          // Low forces wait for "$"
    input  gnss_pkg::nmea_char_t rx_data,
    input  logic                 rx_valid,
    output gnss_pkg::field_buf_t field_buf,       // Leading payload bytes
    output logic                 sentence_valid,  // Checksum matched
    output logic                 checksum_error   // Checksum mismatch
);

    localparam int IDX_W = $clog2(`GNSS_MAX_PAYLOAD + 1);
    localparam int FB_W  = $clog2(`GNSS_FIELD_BYTES);

    typedef enum logic [1:0] {
        S_WAIT_START,
        S_PAYLOAD,
        S_CSUM_HI,
        S_CSUM_LO
    } state_t;

    state_t               state;
    logic [IDX_W-1:0]     pay_idx;   // Payload characters so far
    gnss_pkg::nmea_char_t calc_xor;  // Running checksum
    logic [3:0]           csum_hi;   // Received high nibble
    logic                 is_start;
    logic                 is_star;
    logic                 store_en;
    logic                 is_hex;
    logic [3:0]           hex_val;

    // "$" restarts framing from any state
    assign is_start = enable && rx_valid && (rx_data == `GNSS_CHAR_START);
    assign is_star  = (rx_data == `GNSS_CHAR_STAR);

    assign store_en = enable && rx_valid && (state == S_PAYLOAD) && !is_start
                   && !is_star && (pay_idx < IDX_W'(`GNSS_FIELD_BYTES));

    // Hex digit decode, upper case only
    always_comb begin
        is_hex  = 1'b0;
        hex_val = 4'd0;
        if (rx_data >= `GNSS_CHAR_ZERO && rx_data <= `GNSS_CHAR_ZERO + 8'd9) begin
            is_hex  = 1'b1;
            hex_val = rx_data[3:0];
        end else if (rx_data >= 8'h41 && rx_data <= 8'h46) begin
            is_hex  = 1'b1;
            hex_val = rx_data[3:0] + 4'd9;  // "A" is 0x41
        end
    end

    // ==================================================
    // Sentence FSM
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= S_WAIT_START;
            pay_idx        <= '0;
            calc_xor       <= '0;
            csum_hi        <= '0;
            sentence_valid <= 1'b0;
            checksum_error <= 1'b0;
        end else begin
            sentence_valid <= 1'b0;
            checksum_error <= 1'b0;
            if (!enable) begin
                state <= S_WAIT_START;
            end else if (is_start) begin
                state    <= S_PAYLOAD;
                pay_idx  <= '0;
                calc_xor <= '0;
            end else if (rx_valid) begin
                case (state)
                    S_PAYLOAD: begin
                        if (is_star) begin
                            state <= S_CSUM_HI;
                        end else if (pay_idx == IDX_W'(`GNSS_MAX_PAYLOAD)) begin
                            state <= S_WAIT_START;       // Too long, drop
                        end else begin
                            calc_xor <= calc_xor ^ rx_data;
                            pay_idx  <= pay_idx + 1'b1;
                        end
                    end
                    S_CSUM_HI: begin
                        csum_hi <= hex_val;
                        state   <= is_hex ? S_CSUM_LO : S_WAIT_START;
                    end
                    S_CSUM_LO: begin
                        state <= S_WAIT_START;
                        if (is_hex) begin
                            // Verdict on the second digit itself
                            if ({csum_hi, hex_val} == calc_xor) begin
                                sentence_valid <= 1'b1;
                            end else begin
                                checksum_error <= 1'b1;
                            end
                        end
                    end
                    default: state <= S_WAIT_START;  // Idle until "$"
                endcase
            end
        end
    end

    // ==================================================
    // Field buffer, cleared at each "$"
    // ==================================================
    always_ff @(posedge clk) begin
        if (is_start) begin
            field_buf <= '0;                          // No stale bytes in short sentences
        end else if (store_en) begin
            field_buf[pay_idx[FB_W-1:0]] <= rx_data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/rmc_time_decoder.sv
// ==================================================
// RMC time decoder
// Header and digit checks, hhmmss.sss conversion
// Time registers, time-valid flag and second pulse
// ==================================================
`timescale 1ns/1ps
`default_nettype none
`include "gnss_params.svh"

module rmc_time_decoder (
    input  logic                  clk,
    input  logic                  rst_n,
    input  gnss_pkg::field_buf_t  field_buf,
    input  logic                  sentence_valid,  // Checksum already good
    output gnss_pkg::sec_of_day_t utc_sec_of_day,
    output gnss_pkg::millis_t     utc_millis,
    output logic                  time_valid,      // Sticky until reset
    output logic                  pps              // Whole-second sentence
);

    logic                  header_ok;  // "GPRMC,"
    logic                  dot_ok;
    logic                  digits_ok;
    logic                  rmc_ok;
    logic [6:0]            hours;
    logic [6:0]            minutes;
    logic [6:0]            seconds;
    gnss_pkg::sec_of_day_t sod_calc;
    gnss_pkg::millis_t     ms_calc;

    // ==================================================
    // Character helpers
    // ==================================================
    function automatic logic is_digit(input gnss_pkg::nmea_char_t c);
        return (c >= `GNSS_CHAR_ZERO) && (c <= `GNSS_CHAR_ZERO + 8'd9);
    endfunction

    // Low nibble of an ASCII digit is its value
    function automatic logic [3:0] digit_val(input gnss_pkg::nmea_char_t c);
        return c[3:0];
    endfunction

    function automatic logic [6:0] pair_val(input gnss_pkg::nmea_char_t hi,
                                            input gnss_pkg::nmea_char_t lo);
        return digit_val(hi) * 7'd10 + digit_val(lo);
    endfunction

    // ==================================================
    // Sentence match
    // ==================================================
    assign header_ok = (field_buf[0] == "G") && (field_buf[1] == "P")
                    && (field_buf[2] == "R") && (field_buf[3] == "M")
                    && (field_buf[4] == "C") && (field_buf[5] == `GNSS_CHAR_COMMA);

    assign dot_ok = (field_buf[12] == `GNSS_CHAR_DOT);

    // Bytes 6 to 15 apart from the dot must be digits
    always_comb begin
        digits_ok = 1'b1;
        for (int i = 6; i < `GNSS_FIELD_BYTES; i++) begin
            if (i != 12 && !is_digit(field_buf[i])) begin
                digits_ok = 1'b0;
            end
        end
    end

    assign rmc_ok = header_ok && dot_ok && digits_ok;

    // ==================================================
    // Time conversion
    // ==================================================
    assign hours   = pair_val(field_buf[6], field_buf[7]);
    assign minutes = pair_val(field_buf[8], field_buf[9]);
    assign seconds = pair_val(field_buf[10], field_buf[11]);

    assign sod_calc = hours * 17'd3600 + minutes * 17'd60 + seconds;

    // Fraction digits are the milliseconds
    assign ms_calc = digit_val(field_buf[13]) * 10'd100
                   + digit_val(field_buf[14]) * 10'd10
                   + digit_val(field_buf[15]);

    // ==================================================
    // Output registers
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            utc_sec_of_day <= '0;
            utc_millis     <= '0;
            time_valid     <= 1'b0;
            pps            <= 1'b0;
        end else begin
            pps <= 1'b0;
            if (sentence_valid && rmc_ok) begin
                utc_sec_of_day <= sod_calc;
                utc_millis     <= ms_calc;
                time_valid     <= 1'b1;
                pps            <= (ms_calc == '0);  // On the second
            end
            // Other good sentences leave the time as is
        end
    end

endmodule

`default_nettype wire

// File: verilog/gnss_time_rx.sv
// ==================================================
// GNSS time receiver top level
// Serial receiver, NMEA framer and RMC time decoder
// ==================================================
`timescale 1ns/1ps
`default_nettype none
`include "gnss_params.svh"

module gnss_time_rx (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  gnss_rx,         // Serial line from the module
    input  logic                  enable,
    output gnss_pkg::sec_of_day_t utc_sec_of_day,
    output gnss_pkg::millis_t     utc_millis,
    output logic                  time_valid,
    output logic                  pps,
    output logic                  checksum_error
);

    gnss_pkg::nmea_char_t rx_data;
    logic                 rx_valid;
    gnss_pkg::field_buf_t field_buf;
    logic                 sentence_valid;

    // Byte stream from the serial line
    uart_rx #(
        .CLKS_PER_BIT (`GNSS_CLKS_PER_BIT)
    ) u_uart_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (gnss_rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    nmea_framer u_nmea_framer (
        .clk            (clk),
        .rst_n          (rst_n),
        .enable         (enable),
        .rx_data        (rx_data),
        .rx_valid       (rx_valid),
        .field_buf      (field_buf),
        .sentence_valid (sentence_valid),
        .checksum_error (checksum_error)   // Straight to the pin
    );

    rmc_time_decoder u_rmc_time_decoder (
        .clk            (clk),
        .rst_n          (rst_n),
        .field_buf      (field_buf),
        .sentence_valid (sentence_valid),
        .utc_sec_of_day (utc_sec_of_day),
        .utc_millis     (utc_millis),
        .time_valid     (time_valid),
        .pps            (pps)
    );

endmodule

`default_nettype wire

// File: verification/tb_gnss_time_rx.sv
// ==================================================
// Directed testbench for the GNSS time receiver
// Serial driver, sentence builder, compare tasks
// Pulse monitor and six directed tests
// ==================================================
`timescale 1ns/1ps
`default_nettype none
`include "gnss_params.svh"

module tb_gnss_time_rx;

    localparam int SETTLE_CYCLES = 2 * `GNSS_CLKS_PER_BIT;  // Pipeline drains well within this
    localparam int PULSE_TIMEOUT = 8 * `GNSS_CLKS_PER_BIT;

    logic                  clk;
    logic                  rst_n;
    logic                  gnss_rx;
    logic                  enable;
    gnss_pkg::sec_of_day_t utc_sec_of_day;
    gnss_pkg::millis_t     utc_millis;
    logic                  time_valid;
    logic                  pps;
    logic                  checksum_error;

    int                    pps_count = 0;  // Pulses seen by the monitor
    int                    err_count = 0;
    gnss_pkg::sec_of_day_t pps_sec;        // Time in the pps cycle
    gnss_pkg::millis_t     pps_ms;
    gnss_pkg::sec_of_day_t exp_sec;        // Reference time of day
    gnss_pkg::millis_t     exp_ms;
    int unsigned           seed_out;

    gnss_time_rx u_gnss_time_rx (
        .clk            (clk),
        .rst_n          (rst_n),
        .gnss_rx        (gnss_rx),
        .enable         (enable),
        .utc_sec_of_day (utc_sec_of_day),
        .utc_millis     (utc_millis),
        .time_valid     (time_valid),
        .pps            (pps),
        .checksum_error (checksum_error)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // Sample pulses mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (pps) begin
            pps_count = pps_count + 1;
            pps_sec   = utc_sec_of_day;
            pps_ms    = utc_millis;
        end
        if (checksum_error) begin
            err_count = err_count + 1;
        end
    end

    // ==================================================
    // Failure and compare tasks
    // ==================================================
    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_sec(input string name, input gnss_pkg::sec_of_day_t exp,
                             input gnss_pkg::sec_of_day_t act);
        if (act !== exp) begin
            stop_run($sformatf("[ERROR] %s expected 0x%05h actual 0x%05h", name, exp, act));
        end
    endtask

    task automatic check_millis(input string name, input gnss_pkg::millis_t exp,
                                input gnss_pkg::millis_t act);
        if (act !== exp) begin
            stop_run($sformatf("[ERROR] %s expected 0x%03h actual 0x%03h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("[ERROR] %s expected 0x%01h actual 0x%01h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            stop_run($sformatf("[ERROR] %s expected 0x%0h actual 0x%0h", name, exp, act));
        end
    endtask

    // All three time outputs against the reference
    task automatic check_time();
        check_sec("utc_sec_of_day", exp_sec, utc_sec_of_day);
        check_millis("utc_millis", exp_ms, utc_millis);
        check_bit("time_valid", 1'b1, time_valid);
    endtask

    // ==================================================
    // Serial driver and sentence builder
    // ==================================================
    function automatic gnss_pkg::nmea_char_t hex_char(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return `GNSS_CHAR_ZERO + nib;
        end
        return 8'h37 + nib;  // Upper case "A" to "F"
    endfunction

    function automatic string rmc_payload(input int h, input int m, input int s, input int ms);
        return $sformatf("GPRMC,%02d%02d%02d.%03d,A", h, m, s, ms);
    endfunction

    // Start bit, 8 data bits LSB first, stop bit
    task automatic send_byte(input gnss_pkg::nmea_char_t c);
        logic [9:0] frame;
        frame = {1'b1, c, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            gnss_rx <= frame[i];
            repeat (`GNSS_CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic send_sentence(input string payload, input bit corrupt);
        gnss_pkg::nmea_char_t csum;
        csum = '0;
        for (int i = 0; i < payload.len(); i++) begin
            csum = csum ^ payload[i];  // XOR of all payload characters
        end
        if (corrupt) begin
            csum = ~csum;              // Every bit wrong
        end
        send_byte(`GNSS_CHAR_START);
        for (int i = 0; i < payload.len(); i++) begin
            send_byte(payload[i]);
        end
        send_byte(`GNSS_CHAR_STAR);
        send_byte(hex_char(csum[7:4]));
        send_byte(hex_char(csum[3:0]));
        repeat (SETTLE_CYCLES) @(posedge clk);  // Fixed settling after last stop bit
    endtask

    task automatic wait_pps(input int target);
        int cycles;
        cycles = 0;
        while (pps_count < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > PULSE_TIMEOUT) begin
                stop_run("Timeout while waiting for a pps pulse");
            end
        end
    endtask

    task automatic wait_error(input int target);
        int cycles;
        cycles = 0;
        while (err_count < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > PULSE_TIMEOUT) begin
                stop_run("Timeout while waiting for a checksum error pulse");
            end
        end
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic test_reset_and_first_fix();
        int p0;
        check_bit("time_valid", 1'b0, time_valid);
        check_bit("pps", 1'b0, pps);
        check_bit("checksum_error", 1'b0, checksum_error);
        check_sec("utc_sec_of_day", '0, utc_sec_of_day);
        check_millis("utc_millis", '0, utc_millis);
        p0 = pps_count;
        send_sentence("GPRMC,123519.250,A", 1'b0);
        exp_sec = 17'd45319;  // 12:35:19
        exp_ms  = 10'd250;
        check_time();
        check_count("pps pulses", p0, pps_count);
    endtask

    task automatic test_bad_checksum();
        int e0;
        int p0;
        e0 = err_count;
        p0 = pps_count;
        send_sentence("GPRMC,070000.000,A", 1'b1);
        wait_error(e0 + 1);
        check_count("checksum_error pulses", e0 + 1, err_count);
        check_count("pps pulses", p0, pps_count);
        check_time();  // Still the first fix
    endtask

    task automatic test_ignored_sentences();
        int e0;
        int p0;
        e0 = err_count;
        p0 = pps_count;
        send_sentence("GPGGA,123520.00,4807.038,N", 1'b0);
        check_time();
        send_sentence("GPRMC,12A519.000,A", 1'b0);  // Letter in the minutes
        check_time();
        check_count("checksum_error pulses", e0, err_count);
        check_count("pps pulses", p0, pps_count);
    endtask

    task automatic test_pps_on_second();
        int p0;
        p0 = pps_count;
        send_sentence("GPRMC,235959.000,A", 1'b0);
        exp_sec = 17'd86399;  // Last second of the day
        exp_ms  = '0;
        wait_pps(p0 + 1);
        check_count("pps pulses", p0 + 1, pps_count);
        check_sec("utc_sec_of_day at pps", exp_sec, pps_sec);
        check_millis("utc_millis at pps", exp_ms, pps_ms);
        check_time();
    endtask

    task automatic test_enable_gate();
        @(posedge clk);
        enable <= 1'b0;
        send_sentence("GPRMC,010203.400,A", 1'b0);
        check_time();  // Framer ignored it
        @(posedge clk);
        enable <= 1'b1;
        send_sentence("GPRMC,020304.500,A", 1'b0);
        exp_sec = 17'd7384;  // 02:03:04
        exp_ms  = 10'd500;
        check_time();
    endtask

    task automatic test_random_times();
        int h;
        int m;
        int s;
        int ms;
        int p0;
        for (int n = 0; n < 20; n++) begin
            h  = $urandom % 24;
            m  = $urandom % 60;
            s  = $urandom % 60;
            ms = ($urandom % 4 == 0) ? 0 : $urandom % 1000;  // Some whole seconds
            p0 = pps_count;
            send_sentence(rmc_payload(h, m, s, ms), 1'b0);
            exp_sec = gnss_pkg::sec_of_day_t'(h * 3600 + m * 60 + s);
            exp_ms  = gnss_pkg::millis_t'(ms);
            if (ms == 0) begin
                wait_pps(p0 + 1);
                check_sec("utc_sec_of_day at pps", exp_sec, pps_sec);
            end
            check_count("pps pulses", p0 + ((ms == 0) ? 1 : 0), pps_count);
            check_time();
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        rst_n    = 1'b0;
        gnss_rx  = 1'b1;  // Line idles high
        enable   = 1'b1;
        exp_sec  = '0;
        exp_ms   = '0;
        seed_out = $urandom(32'hdd5f1536);
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        test_reset_and_first_fix();
        test_bad_checksum();
        test_ignored_sentences();
        test_pps_on_second();
        test_enable_gate();
        test_random_times();
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: gnss_time_rx.f
+incdir+verilog
verilog/gnss_pkg.sv
verilog/uart_rx.sv
verilog/nmea_framer.sv
verilog/rmc_time_decoder.sv
verilog/gnss_time_rx.sv
verification/tb_gnss_time_rx.sv
